// ==== source/axi_pkg.sv ====
package axi_pkg;

    // Bus widths
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;

    typedef logic [3:0]  axi_id_t;
    typedef logic [7:0]  axi_len_t;
    typedef logic [2:0]  axi_size_t;
    typedef logic [1:0]  axi_burst_t;
    typedef logic [1:0]  axi_resp_t;

    // Cache write width, 0 byte, 1 halfword, else word
    typedef logic [1:0]  wtype_t;

    localparam axi_len_t   AXI_LEN_ONE    = 8'd0;
    localparam axi_len_t   AXI_LEN_FOUR   = 8'd3;
    localparam axi_size_t  AXI_SIZE_WORD  = 3'd2;
    localparam axi_burst_t AXI_BURST_INCR = 2'd1;
    localparam axi_resp_t  AXI_RESP_OKAY  = 2'd0;

    localparam strb_t STRB_BYTE  = 4'b0001;
    localparam strb_t STRB_HWORD = 4'b0011;
    localparam strb_t STRB_WORD  = 4'b1111;

    // Shared by AR and AW
    typedef struct packed {
        axi_id_t    id;
        addr_t      addr;
        axi_len_t   len;
        axi_size_t  size;
        axi_burst_t burst;
    } axi_ax_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
        logic  last;
    } axi_w_t;

    typedef struct packed {
        axi_id_t id;
        data_t   data;
        logic    last;
    } axi_r_t;

    typedef struct packed {
        axi_id_t   id;
        axi_resp_t resp;
    } axi_b_t;

    // Master to slave
    typedef struct packed {
        axi_ax_t ar;
        logic    arvalid;
        axi_ax_t aw;
        logic    awvalid;
        axi_w_t  w;
        logic    wvalid;
        logic    rready;
        logic    bready;
    } axi_m2s_t;

    // Slave to master
    typedef struct packed {
        logic   arready;
        logic   awready;
        logic   wready;
        axi_r_t r;
        logic   rvalid;
        axi_b_t b;
        logic   bvalid;
    } axi_s2m_t;

endpackage

// ==== source/axi_master.sv ====
module axi_master import axi_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    // Cache side
    input  logic     creq_i,
    input  logic     sctrl_rd_i,
    input  logic     cwrite_i,
    input  wtype_t   cwtype_i,
    input  data_t    cdatain_i,
    input  addr_t    caddr_i,
    // AXI side
    input  axi_s2m_t s2m_i,
    output axi_m2s_t m2s_o,
    output data_t    dataout_o,
    output logic     wait_o
);

    typedef enum logic [2:0] {
        IDLE,
        AR_CH,
        R_CH,
        AW_CH,
        W_CH,
        B_CH
    } state_e;

    state_e state_q;
    state_e state_d;

    logic  arhns;
    logic  awhns;
    logic  rhns;
    logic  whns;
    logic  bhns;
    logic  rdfin;
    logic  req_rd;
    logic  req_wr;
    strb_t wstrb;
    data_t rdata_q;

    assign req_rd = (creq_i & ~cwrite_i) | sctrl_rd_i;
    assign req_wr = creq_i & cwrite_i;

    assign arhns = m2s_o.arvalid & s2m_i.arready;
    assign awhns = m2s_o.awvalid & s2m_i.awready;
    assign rhns  = m2s_o.rready  & s2m_i.rvalid;
    assign whns  = m2s_o.wvalid  & s2m_i.wready;
    assign bhns  = m2s_o.bready  & s2m_i.bvalid;
    assign rdfin = rhns & s2m_i.r.last;

    // Narrow writes use the low lanes only
    always_comb begin
        case (cwtype_i)
            2'd0:    wstrb = STRB_BYTE;
            2'd1:    wstrb = STRB_HWORD;
            default: wstrb = STRB_WORD;
        endcase
    end

    always_comb begin
        m2s_o = '0;

        m2s_o.ar.id    = '0;
        m2s_o.ar.addr  = caddr_i;
        m2s_o.ar.len   = sctrl_rd_i ? AXI_LEN_FOUR : AXI_LEN_ONE;
        m2s_o.ar.size  = AXI_SIZE_WORD;
        m2s_o.ar.burst = AXI_BURST_INCR;

        m2s_o.aw.id    = '0;
        m2s_o.aw.addr  = caddr_i;
        m2s_o.aw.len   = AXI_LEN_ONE;
        m2s_o.aw.size  = AXI_SIZE_WORD;
        m2s_o.aw.burst = AXI_BURST_INCR;

        m2s_o.w.data = cdatain_i;
        m2s_o.w.strb = wstrb;
        m2s_o.w.last = 1'b1;

        case (state_q)
            IDLE: begin
                m2s_o.arvalid = req_rd;
                // Read wins if both show up
                m2s_o.awvalid = req_wr & ~req_rd;
            end
            AR_CH: m2s_o.arvalid = 1'b1;
            R_CH:  m2s_o.rready  = 1'b1;
            AW_CH: m2s_o.awvalid = 1'b1;
            W_CH:  m2s_o.wvalid  = 1'b1;
            B_CH:  m2s_o.bready  = 1'b1;
            default: ;
        endcase
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (m2s_o.arvalid) begin
                    state_d = arhns ? R_CH : AR_CH;
                end else if (m2s_o.awvalid) begin
                    state_d = awhns ? W_CH : AW_CH;
                end
            end
            AR_CH: state_d = arhns ? R_CH : AR_CH;
            R_CH:  state_d = rdfin ? IDLE : R_CH;
            AW_CH: state_d = awhns ? W_CH : AW_CH;
            W_CH:  state_d = whns ? B_CH : W_CH;
            B_CH:  state_d = bhns ? IDLE : B_CH;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Last beat kept for the cache between beats
    always_ff @(posedge clk) begin
        if (rhns) begin
            rdata_q <= s2m_i.r.data;
        end
    end

    assign dataout_o = rhns ? s2m_i.r.data : rdata_q;

    // Low wait marks a delivered beat or an accepted write
    always_comb begin
        case (state_q)
            IDLE:    wait_o = req_rd | req_wr;
            AR_CH:   wait_o = 1'b1;
            R_CH:    wait_o = ~rhns;
            AW_CH:   wait_o = 1'b1;
            W_CH:    wait_o = ~whns;
            B_CH:    wait_o = req_rd | req_wr;
            default: wait_o = 1'b0;
        endcase
    end

    ar_stable: assert property (@(posedge clk) disable iff (!rst)
        m2s_o.arvalid && !s2m_i.arready |=> m2s_o.arvalid);

    ar_aw_excl: assert property (@(posedge clk) disable iff (!rst)
        !(m2s_o.arvalid && m2s_o.awvalid));

endmodule

// ==== source/axi_sram_slave.sv ====
module axi_sram_slave import axi_pkg::*; #(
    parameter int unsigned MEM_WORDS  = 256,
    parameter int unsigned RESP_DELAY = 1
) (
    input  logic     clk,
    input  logic     rst,
    input  axi_m2s_t m2s_i,
    output axi_s2m_t s2m_o
);

    localparam int unsigned IDX_W     = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
    localparam int unsigned CNT_W     = (RESP_DELAY > 1) ? $clog2(RESP_DELAY) : 1;
    // Cycles spent in a wait state, beyond the handshake cycle
    localparam int unsigned WAIT_LOAD = (RESP_DELAY > 1) ? RESP_DELAY - 2 : 0;

    typedef logic [IDX_W-1:0] idx_t;

    typedef enum logic [2:0] {
        IDLE,
        READ_WAIT,
        READ_BURST,
        WRITE_WAIT,
        WRITE_DATA,
        WRITE_RESP
    } state_e;

    state_e           state_q;
    state_e           state_d;
    logic [CNT_W-1:0] delay_q;
    logic             delay_done;
    axi_len_t         beat_q;
    axi_len_t         len_q;
    idx_t             idx_q;
    data_t            mem [MEM_WORDS];

    logic arhns;
    logic awhns;
    logic rhns;
    logic whns;
    logic bhns;

    function automatic idx_t word_index(addr_t addr);
        return idx_t'((addr >> 2) % MEM_WORDS);
    endfunction

    function automatic idx_t next_index(idx_t idx);
        return (idx == idx_t'(MEM_WORDS - 1)) ? '0 : idx + 1'b1;
    endfunction

    assign arhns = m2s_i.arvalid & s2m_o.arready;
    assign awhns = m2s_i.awvalid & s2m_o.awready;
    assign rhns  = m2s_i.rready  & s2m_o.rvalid;
    assign whns  = m2s_i.wvalid  & s2m_o.wready;
    assign bhns  = m2s_i.bready  & s2m_o.bvalid;

    assign delay_done = (delay_q == '0);

    always_comb begin
        s2m_o         = '0;
        s2m_o.arready = (state_q == IDLE);
        s2m_o.awready = (state_q == IDLE);
        s2m_o.wready  = (state_q == WRITE_DATA);
        s2m_o.r.id    = '0;
        s2m_o.r.data  = mem[idx_q];
        s2m_o.r.last  = (beat_q == len_q);
        s2m_o.rvalid  = (state_q == READ_BURST);
        s2m_o.b.id    = '0;
        s2m_o.b.resp  = AXI_RESP_OKAY;
        s2m_o.bvalid  = (state_q == WRITE_RESP);
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (arhns) begin
                    state_d = (RESP_DELAY > 1) ? READ_WAIT : READ_BURST;
                end else if (awhns) begin
                    state_d = (RESP_DELAY > 1) ? WRITE_WAIT : WRITE_DATA;
                end
            end
            READ_WAIT:  state_d = delay_done ? READ_BURST : READ_WAIT;
            READ_BURST: state_d = (rhns && s2m_o.r.last) ? IDLE : READ_BURST;
            WRITE_WAIT: state_d = delay_done ? WRITE_DATA : WRITE_WAIT;
            WRITE_DATA: state_d = whns ? WRITE_RESP : WRITE_DATA;
            WRITE_RESP: state_d = bhns ? IDLE : WRITE_RESP;
            default:    state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q <= IDLE;
            delay_q <= '0;
            beat_q  <= '0;
        end else begin
            state_q <= state_d;
            // Counter idles at zero once the wait is over
            if (arhns || awhns) begin
                delay_q <= CNT_W'(WAIT_LOAD);
            end else if (!delay_done) begin
                delay_q <= delay_q - 1'b1;
            end
            if (arhns) begin
                beat_q <= '0;
            end else if (rhns) begin
                beat_q <= beat_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (arhns) begin
            idx_q <= word_index(m2s_i.ar.addr);
            len_q <= m2s_i.ar.len;
        end else if (awhns) begin
            idx_q <= word_index(m2s_i.aw.addr);
        end else if (rhns) begin
            idx_q <= next_index(idx_q);
        end
    end

    // Byte lanes follow the strobe
    always_ff @(posedge clk) begin
        if (whns) begin
            for (int i = 0; i < $bits(strb_t); i++) begin
                if (m2s_i.w.strb[i]) begin
                    mem[idx_q][8*i +: 8] <= m2s_i.w.data[8*i +: 8];
                end
            end
        end
    end

    r_b_excl: assert property (@(posedge clk) disable iff (!rst)
        !(s2m_o.rvalid && s2m_o.bvalid));

    rlast_final: assert property (@(posedge clk) disable iff (!rst)
        rhns && s2m_o.r.last |=> !s2m_o.rvalid);

endmodule

// ==== source/mem_subsystem.sv ====
module mem_subsystem import axi_pkg::*; #(
    parameter int unsigned MEM_WORDS  = 256,
    parameter int unsigned RESP_DELAY = 1
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   creq_i,
    input  logic   sctrl_rd_i,
    input  logic   cwrite_i,
    input  wtype_t cwtype_i,
    input  data_t  cdatain_i,
    input  addr_t  caddr_i,
    output data_t  dataout_o,
    output logic   wait_o
);

    axi_m2s_t m2s;
    axi_s2m_t s2m;

    axi_master u_master (
        .clk        (clk),
        .rst        (rst),
        .creq_i     (creq_i),
        .sctrl_rd_i (sctrl_rd_i),
        .cwrite_i   (cwrite_i),
        .cwtype_i   (cwtype_i),
        .cdatain_i  (cdatain_i),
        .caddr_i    (caddr_i),
        .s2m_i      (s2m),
        .m2s_o      (m2s),
        .dataout_o  (dataout_o),
        .wait_o     (wait_o)
    );

    axi_sram_slave #(
        .MEM_WORDS  (MEM_WORDS),
        .RESP_DELAY (RESP_DELAY)
    ) u_sram (
        .clk   (clk),
        .rst   (rst),
        .m2s_i (m2s),
        .s2m_o (s2m)
    );

endmodule

// ==== verif/tb_checker.sv ====
module tb_checker import axi_pkg::*; #(
    parameter int unsigned MEM_WORDS = 256
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   creq_i,
    input  logic   sctrl_rd_i,
    input  logic   cwrite_i,
    input  wtype_t cwtype_i,
    input  data_t  cdatain_i,
    input  addr_t  caddr_i,
    input  data_t  dataout_i,
    input  logic   wait_i,
    input  int     test_num_i,
    input  logic   test_end_i,
    output int     checks_o,
    output int     errors_o,
    output int     tests_failed_o
);

    data_t model_mem [MEM_WORDS];
    logic  model_valid [MEM_WORDS];
    int    beat;
    int    test_checks;
    int    test_errors;
    // Expected value of dataout between beats
    logic  hold_known;
    data_t hold_data;

    function automatic string test_name(int n);
        case (n)
            1:       return "reset idle";
            2:       return "word write and read back";
            3:       return "narrow writes";
            4:       return "burst line fill";
            5:       return "back-to-back mix";
            default: return "unnamed";
        endcase
    endfunction

    // Bits of the word replaced by a cache write
    function automatic data_t lane_mask(wtype_t wt);
        case (wt)
            2'd0:    return 32'h0000_00ff;
            2'd1:    return 32'h0000_ffff;
            default: return 32'hffff_ffff;
        endcase
    endfunction

    function automatic int unsigned word_of(addr_t addr, int unsigned offset);
        return ((addr >> 2) % MEM_WORDS + offset) % MEM_WORDS;
    endfunction

    task automatic report_error(string msg);
        $display("mismatch at %0t: %s", $time, msg);
        errors_o++;
        test_errors++;
    endtask

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            model_valid[i] = 1'b0;
        end
        beat           = 0;
        test_checks    = 0;
        test_errors    = 0;
        hold_known     = 1'b0;
        hold_data      = '0;
        checks_o       = 0;
        errors_o       = 0;
        tests_failed_o = 0;
    end

    // Inputs and outputs are settled at the falling edge
    always @(negedge clk) begin : watch
        logic        rd;
        logic        wr;
        logic        beat_now;
        int unsigned idx;
        data_t       mask;
        rd = (creq_i && !cwrite_i) || sctrl_rd_i;
        wr = creq_i && cwrite_i && !rd;
        beat_now = rst && rd && wait_i === 1'b0;
        if (!rd && !wr) begin
            if (wait_i !== 1'b0) begin
                report_error($sformatf("wait_o is %b with no request", wait_i));
            end
        end else if (rst && wait_i === 1'b0) begin
            if (rd) begin
                idx = word_of(caddr_i, beat);
                // Words never written have no known value
                if (model_valid[idx]) begin
                    checks_o++;
                    test_checks++;
                    if (dataout_i !== model_mem[idx]) begin
                        report_error($sformatf("word %0d beat %0d read %h, expected %h",
                            idx, beat, dataout_i, model_mem[idx]));
                    end
                end
                hold_known = model_valid[idx];
                hold_data  = model_mem[idx];
                beat++;
                if (beat == (sctrl_rd_i ? 4 : 1)) begin
                    beat = 0;
                end
            end else begin
                idx  = word_of(caddr_i, 0);
                mask = lane_mask(cwtype_i);
                model_mem[idx] = (model_mem[idx] & ~mask) | (cdatain_i & mask);
                if (mask == '1) begin
                    model_valid[idx] = 1'b1;
                end
            end
        end
        // Outside a beat the last beat received stays on dataout
        if (rst && !beat_now && hold_known) begin
            if (dataout_i !== hold_data) begin
                report_error($sformatf("dataout %h between beats, expected %h",
                    dataout_i, hold_data));
            end
        end
        if (test_end_i) begin
            if (test_errors == 0) begin
                $display("test %0d %s: passed, %0d reads checked", test_num_i,
                    test_name(test_num_i), test_checks);
            end else begin
                $display("test %0d %s: failed with %0d errors", test_num_i,
                    test_name(test_num_i), test_errors);
                tests_failed_o++;
            end
            test_checks = 0;
            test_errors = 0;
        end
    end

endmodule

// ==== verif/tb_mem_subsystem.sv ====
module tb_mem_subsystem import axi_pkg::*; ();

    localparam int unsigned MEM_WORDS  = 256;
    localparam int unsigned RESP_DELAY = 1;
    localparam int RESET_CYCLES = 16;
    localparam int WORD_COUNT   = 32;
    localparam int MIX_COUNT    = 64;
    localparam int NUM_TESTS    = 5;
    // Requests of tests 2 to 5
    localparam int TOTAL_REQS   = 2 * WORD_COUNT + 20 + 10 + MIX_COUNT;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + 2 * TOTAL_REQS * (RESP_DELAY + 6);
    localparam int KIND_READ    = 0;
    localparam int KIND_LINE    = 1;
    localparam int KIND_WRITE   = 2;

    logic        clk;
    logic        rst;
    logic        creq;
    logic        sctrl_rd;
    logic        cwrite;
    wtype_t      cwtype;
    data_t       cdatain;
    addr_t       caddr;
    data_t       dataout;
    logic        cache_wait;
    logic [31:0] lfsr_state;
    int          test_num;
    logic        test_end;
    int          checks;
    int          errors;
    int          tests_failed;
    int          cycles = 0;
    addr_t       addrs [WORD_COUNT];

    mem_subsystem #(
        .MEM_WORDS  (MEM_WORDS),
        .RESP_DELAY (RESP_DELAY)
    ) uut (
        .clk        (clk),
        .rst        (rst),
        .creq_i     (creq),
        .sctrl_rd_i (sctrl_rd),
        .cwrite_i   (cwrite),
        .cwtype_i   (cwtype),
        .cdatain_i  (cdatain),
        .caddr_i    (caddr),
        .dataout_o  (dataout),
        .wait_o     (cache_wait)
    );

    tb_checker #(
        .MEM_WORDS (MEM_WORDS)
    ) u_checker (
        .clk            (clk),
        .rst            (rst),
        .creq_i         (creq),
        .sctrl_rd_i     (sctrl_rd),
        .cwrite_i       (cwrite),
        .cwtype_i       (cwtype),
        .cdatain_i      (cdatain),
        .caddr_i        (caddr),
        .dataout_i      (dataout),
        .wait_i         (cache_wait),
        .test_num_i     (test_num),
        .test_end_i     (test_end),
        .checks_o       (checks),
        .errors_o       (errors),
        .tests_failed_o (tests_failed)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: requests still pending after %0d cycles", cycles);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    function automatic logic [31:0] take_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    function automatic addr_t word_addr(int unsigned idx);
        return addr_t'(idx % MEM_WORDS) << 2;
    endfunction

    task automatic set_idle();
        creq     = 1'b0;
        sctrl_rd = 1'b0;
        cwrite   = 1'b0;
        cwtype   = 2'd0;
        cdatain  = '0;
        caddr    = '0;
    endtask

    task automatic idle_cycles(int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Holds one request until its last low wait, ends at the next drive point
    task automatic issue(int kind, addr_t addr, data_t data, wtype_t wt);
        int beats;
        int need;
        need     = (kind == KIND_LINE) ? 4 : 1;
        beats    = 0;
        creq     = 1'b1;
        sctrl_rd = (kind == KIND_LINE);
        cwrite   = (kind == KIND_WRITE);
        cwtype   = wt;
        cdatain  = data;
        caddr    = addr;
        while (beats < need) begin
            @(negedge clk);
            if (cache_wait === 1'b0) begin
                beats++;
            end
        end
        @(posedge clk);
        #1;
    endtask

    task automatic end_test();
        set_idle();
        test_end = 1'b1;
        idle_cycles(1);
        test_end = 1'b0;
        test_num++;
    endtask

    initial begin : main
        int unsigned base;
        int          kind;
        lfsr_state = 32'd55;
        rst        = 1'b0;
        test_num   = 1;
        test_end   = 1'b0;
        set_idle();

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b1;
        idle_cycles(4);
        end_test();

        for (int i = 0; i < WORD_COUNT; i++) begin
            addrs[i] = word_addr(take_bits(8));
            issue(KIND_WRITE, addrs[i], take_bits(32), 2'd2);
        end
        for (int i = 0; i < WORD_COUNT; i++) begin
            issue(KIND_READ, addrs[i], '0, 2'd0);
        end
        end_test();

        for (int i = 0; i < 4; i++) begin
            issue(KIND_WRITE, addrs[i], take_bits(32), 2'd2);
            issue(KIND_WRITE, addrs[i], take_bits(32), 2'd0);
            issue(KIND_READ, addrs[i], '0, 2'd0);
            issue(KIND_WRITE, addrs[i], take_bits(32), 2'd1);
            issue(KIND_READ, addrs[i], '0, 2'd0);
        end
        end_test();

        // Second line wraps past the top of memory
        for (int line = 0; line < 2; line++) begin
            base = (line == 0) ? take_bits(8) : MEM_WORDS - 2;
            for (int k = 0; k < 4; k++) begin
                issue(KIND_WRITE, word_addr(base + k), take_bits(32), 2'd2);
            end
            issue(KIND_LINE, word_addr(base), '0, 2'd0);
        end
        end_test();

        for (int i = 0; i < MIX_COUNT; i++) begin
            kind = take_bits(2);
            base = take_bits(5);
            if (kind == 0) begin
                issue(KIND_READ, addrs[base], '0, 2'd0);
            end else if (kind == 1) begin
                issue(KIND_LINE, addrs[base], '0, 2'd0);
            end else begin
                issue(KIND_WRITE, addrs[base], take_bits(32), take_bits(2));
            end
        end
        end_test();

        idle_cycles(2);
        $display("%0d tests, %0d failed, %0d reads checked, %0d errors",
            NUM_TESTS, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
source/axi_pkg.sv
source/axi_master.sv
source/axi_sram_slave.sv
source/mem_subsystem.sv
verif/tb_checker.sv
verif/tb_mem_subsystem.sv

// ==== Bender.yml ====
package:
  name: mem_subsystem

sources:
  - source/axi_pkg.sv
  - source/axi_master.sv
  - source/axi_sram_slave.sv
  - source/mem_subsystem.sv
  - target: test
    files:
      - verif/tb_checker.sv
      - verif/tb_mem_subsystem.sv
